//--- source/int_pipe_pkg.sv
package int_pipe_pkg;

    typedef logic [63:0] xlen_t;     // one register or data value
    typedef logic [4:0]  reg_addr_t; // register number x0 to x31
    typedef logic [2:0]  alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLL = 3'd5; // shift amount is b[5:0]
    localparam alu_op_t ALU_SRL = 3'd6; // logical, shift amount is b[5:0]
    localparam alu_op_t ALU_SLT = 3'd7; // signed compare, result is 1 or 0

    // operation as it arrives on the issue port
    typedef struct packed {
        alu_op_t   alu_op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm; // operand b comes from imm, rs2 is ignored
        xlen_t     imm;     // already sign-extended
    } issue_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        reg_addr_t rd;
        xlen_t     op_a;
        xlen_t     op_b;
    } ex_pkt_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     data;
    } wb_pkt_t;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
    } result_t;

endpackage

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import int_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  xlen_t     wdata,
    output xlen_t     rdata1,
    output xlen_t     rdata2
);

    xlen_t regs [31:1]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // a read of the register being written this cycle sees the new value,
    // which covers the operation three stages ahead
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else if (we && waddr == raddr1) begin
            rdata1 = wdata;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else if (we && waddr == raddr2) begin
            rdata2 = wdata;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

//--- source/operand_forward.sv
`timescale 1ns/1ps

module operand_forward
    import int_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      issue_valid,
    input  issue_t    issue,
    input  xlen_t     rdata1,
    input  xlen_t     rdata2,
    input  xlen_t     ex_alu_res, // result of the operation one ahead
    input  wb_pkt_t   mem_pkt,    // operation two ahead
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output ex_pkt_t   ex_pkt
);

    xlen_t fwd_a;
    xlen_t fwd_b;
    xlen_t op_b;

    // newest value of one source register, nearest producer first
    function automatic xlen_t pick_operand(
        input reg_addr_t src,
        input xlen_t     rf_data,
        input ex_pkt_t   ex,
        input xlen_t     ex_res,
        input wb_pkt_t   mem
    );
        xlen_t val;
        if (ex.valid && ex.rd != '0 && ex.rd == src) begin
            val = ex_res;
        end else if (mem.valid && mem.rd != '0 && mem.rd == src) begin
            val = mem.data;
        end else if (src != '0) begin
            val = rf_data; // includes the write-through path for distance three
        end else begin
            val = '0;
        end
        return val;
    endfunction

    assign raddr1 = issue.rs1;
    assign raddr2 = issue.rs2;

    always_comb begin
        fwd_a = pick_operand(issue.rs1, rdata1, ex_pkt, ex_alu_res, mem_pkt);
        fwd_b = pick_operand(issue.rs2, rdata2, ex_pkt, ex_alu_res, mem_pkt);
        op_b  = issue.use_imm ? issue.imm : fwd_b;
    end

    // issue_ready is the inverse of stall, so any valid issue here is accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_pkt <= '0;
        end else if (!stall) begin
            ex_pkt.valid  <= issue_valid;
            ex_pkt.alu_op <= issue.alu_op;
            ex_pkt.rd     <= issue.rd;
            ex_pkt.op_a   <= fwd_a;
            ex_pkt.op_b   <= op_b;
        end
    end

endmodule

//--- source/int_alu.sv
`timescale 1ns/1ps

module int_alu
    import int_pipe_pkg::*;
(
    input  alu_op_t op,
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   res
);

    logic [5:0] shamt;
    logic       lt;

    assign shamt = b[5:0];
    assign lt    = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                res = a + b;
            end
            ALU_SUB: begin
                res = a - b;
            end
            ALU_AND: begin
                res = a & b;
            end
            ALU_OR: begin
                res = a | b;
            end
            ALU_XOR: begin
                res = a ^ b;
            end
            ALU_SLL: begin
                res = a << shamt;
            end
            ALU_SRL: begin
                res = a >> shamt; // zero fill from the top
            end
            ALU_SLT: begin
                res = {63'd0, lt};
            end
            default: begin
                res = '0;
            end
        endcase
    end

endmodule

//--- source/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage
    import int_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  ex_pkt_t   ex_pkt,
    input  xlen_t     alu_res,
    input  logic      result_ready,
    output logic      stall,
    output wb_pkt_t   mem_pkt,
    output logic      we,
    output reg_addr_t waddr,
    output xlen_t     wdata,
    output logic      result_valid,
    output result_t   result
);

    wb_pkt_t wb_pkt;
    logic    result_xfer;

    // a result that is waiting freezes every stage behind it
    assign stall       = wb_pkt.valid && !result_ready;
    assign result_xfer = wb_pkt.valid && result_ready;

    // memory stage only carries the ALU result along
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_pkt <= '0;
        end else if (!stall) begin
            mem_pkt.valid <= ex_pkt.valid;
            mem_pkt.rd    <= ex_pkt.rd;
            mem_pkt.data  <= alu_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_pkt <= '0;
        end else if (!stall) begin
            wb_pkt <= mem_pkt;
        end
    end

    // register file is updated in the same cycle the result leaves
    assign we    = result_xfer && wb_pkt.rd != '0;
    assign waddr = wb_pkt.rd;
    assign wdata = wb_pkt.data;

    // x0 writes still report their data
    assign result_valid = wb_pkt.valid;
    assign result.rd    = wb_pkt.rd;
    assign result.data  = wb_pkt.data;

endmodule

//--- source/int_pipe_top.sv
`timescale 1ns/1ps

module int_pipe_top
    import int_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    issue_valid,
    output logic    issue_ready,
    input  issue_t  issue,
    output logic    result_valid,
    input  logic    result_ready,
    output result_t result
);

    logic      stall;
    ex_pkt_t   ex_pkt;
    xlen_t     alu_res;
    wb_pkt_t   mem_pkt;
    logic      we;
    reg_addr_t waddr;
    xlen_t     wdata;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    xlen_t     rdata1;
    xlen_t     rdata2;

    assign issue_ready = !stall;

    reg_file i_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    operand_forward i_operand_forward (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue       (issue),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .ex_alu_res  (alu_res),
        .mem_pkt     (mem_pkt),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .ex_pkt      (ex_pkt)
    );

    int_alu i_int_alu (
        .op  (ex_pkt.alu_op),
        .a   (ex_pkt.op_a),
        .b   (ex_pkt.op_b),
        .res (alu_res)
    );

    mem_wb_stage i_mem_wb_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_pkt       (ex_pkt),
        .alu_res      (alu_res),
        .result_ready (result_ready),
        .stall        (stall),
        .mem_pkt      (mem_pkt),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

//--- testbench/tb_int_pipe.sv
`timescale 1ns/1ps

module tb_int_pipe import int_pipe_pkg::*; ();

    localparam int CLK_PERIOD       = 40;
    localparam int DRIVE_DLY        = 2;
    localparam int RESET_CYCLES     = 16;
    localparam int MAX_ENTRIES      = 40;
    localparam int CYCLES_PER_ENTRY = 10;
    localparam int READY_PERCENT    = 70;
    localparam logic [31:0] SEED    = 32'h90c0_97d1;

    logic    clk;
    logic    rst_n;
    logic    issue_valid;
    logic    issue_ready;
    issue_t  issue;
    logic    result_valid;
    logic    result_ready;
    result_t result;

    string   test_name [MAX_ENTRIES];
    issue_t  test_op   [MAX_ENTRIES];
    xlen_t   test_exp  [MAX_ENTRIES];
    int      n_entries;
    int      results_seen;
    logic    table_ready;
    int      idx;
    logic    accepted;
    logic    held;
    result_t held_result;

    int_pipe_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_entry(
        input string     name,
        input alu_op_t   op,
        input reg_addr_t rd,
        input reg_addr_t rs1,
        input reg_addr_t rs2,
        input logic      use_imm,
        input xlen_t     imm,
        input xlen_t     expected
    );
        issue_t entry;
        entry.alu_op  = op;
        entry.rd      = rd;
        entry.rs1     = rs1;
        entry.rs2     = rs2;
        entry.use_imm = use_imm;
        entry.imm     = imm;
        test_name[n_entries] = name;
        test_op[n_entries]   = entry;
        test_exp[n_entries]  = expected;
        n_entries++;
    endtask

    // expected data follows from the ALU rules and the values written by earlier rows
    task automatic build_table();
        add_entry("reset_add",        ALU_ADD, 5'd3,  5'd1,  5'd2,  1'b0, 64'd0,   64'd0);
        add_entry("li_x1",            ALU_ADD, 5'd1,  5'd0,  5'd0,  1'b1, 64'd100, 64'd100);
        add_entry("ex_fwd_addi",      ALU_ADD, 5'd2,  5'd1,  5'd0,  1'b1, 64'd5,   64'd105);
        add_entry("ex_mem_fwd_add",   ALU_ADD, 5'd3,  5'd2,  5'd1,  1'b0, 64'd0,   64'd205);
        add_entry("li_minus_one",     ALU_ADD, 5'd4,  5'd0,  5'd0,  1'b1,
                  64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF);
        add_entry("li_x5",            ALU_ADD, 5'd5,  5'd0,  5'd0,  1'b1, 64'd7,   64'd7);
        add_entry("rf_bypass_dist3",  ALU_ADD, 5'd6,  5'd3,  5'd0,  1'b0, 64'd0,   64'd205);
        add_entry("mem_fwd_dist2",    ALU_SUB, 5'd7,  5'd5,  5'd4,  1'b0, 64'd0,   64'd8);
        add_entry("write_x0",         ALU_ADD, 5'd0,  5'd1,  5'd0,  1'b1, 64'd55,  64'd155);
        add_entry("read_x0_dist1",    ALU_ADD, 5'd8,  5'd0,  5'd5,  1'b0, 64'd0,   64'd7);
        add_entry("read_x0_dist2",    ALU_ADD, 5'd9,  5'd0,  5'd0,  1'b0, 64'd0,   64'd0);
        add_entry("li_x10",           ALU_ADD, 5'd10, 5'd0,  5'd0,  1'b1, 64'h0F0F, 64'h0F0F);
        add_entry("li_x11",           ALU_ADD, 5'd11, 5'd0,  5'd0,  1'b1, 64'h00FF, 64'h00FF);
        add_entry("and_op",           ALU_AND, 5'd12, 5'd10, 5'd11, 1'b0, 64'd0,   64'h000F);
        add_entry("or_op",            ALU_OR,  5'd13, 5'd10, 5'd11, 1'b0, 64'd0,   64'h0FFF);
        add_entry("xor_op",           ALU_XOR, 5'd14, 5'd10, 5'd11, 1'b0, 64'd0,   64'h0FF0);
        add_entry("li_one",           ALU_ADD, 5'd15, 5'd0,  5'd0,  1'b1, 64'd1,   64'd1);
        add_entry("li_63",            ALU_ADD, 5'd16, 5'd0,  5'd0,  1'b1, 64'd63,  64'd63);
        add_entry("sll_by_63",        ALU_SLL, 5'd17, 5'd15, 5'd16, 1'b0, 64'd0,
                  64'h8000_0000_0000_0000);
        add_entry("srl_by_63",        ALU_SRL, 5'd18, 5'd17, 5'd16, 1'b0, 64'd0,   64'd1);
        add_entry("srl_neg_by_63",    ALU_SRL, 5'd19, 5'd4,  5'd16, 1'b0, 64'd0,   64'd1);
        add_entry("sll_neg_by_1",     ALU_SLL, 5'd20, 5'd4,  5'd15, 1'b0, 64'd0,
                  64'hFFFF_FFFF_FFFF_FFFE);
        add_entry("slt_negative",     ALU_SLT, 5'd21, 5'd4,  5'd15, 1'b0, 64'd0,   64'd1);
        add_entry("slt_positive",     ALU_SLT, 5'd22, 5'd15, 5'd4,  1'b0, 64'd0,   64'd0);
        add_entry("slt_most_neg",     ALU_SLT, 5'd23, 5'd17, 5'd4,  1'b0, 64'd0,   64'd1);
        add_entry("sll_low6_imm",     ALU_SLL, 5'd24, 5'd15, 5'd0,  1'b1, 64'd68,  64'd16);
        add_entry("sub_regs",         ALU_SUB, 5'd25, 5'd7,  5'd8,  1'b0, 64'd0,   64'd1);
        add_entry("slt_equal",        ALU_SLT, 5'd26, 5'd5,  5'd5,  1'b0, 64'd0,   64'd0);
        add_entry("add_after_slt",    ALU_ADD, 5'd27, 5'd26, 5'd21, 1'b0, 64'd0,   64'd1);
        add_entry("addi_negative",    ALU_ADD, 5'd28, 5'd6,  5'd0,  1'b1,
                  64'hFFFF_FFFF_FFFF_FFFB, 64'd200);
        add_entry("li_x29_old",       ALU_ADD, 5'd29, 5'd0,  5'd0,  1'b1, 64'd3,   64'd3);
        add_entry("li_x29_new",       ALU_ADD, 5'd29, 5'd0,  5'd0,  1'b1, 64'd9,   64'd9);
        add_entry("newest_over_mem",  ALU_ADD, 5'd30, 5'd29, 5'd0,  1'b0, 64'd0,   64'd9);
        add_entry("newest_over_rf",   ALU_ADD, 5'd31, 5'd29, 5'd29, 1'b0, 64'd0,   64'd18);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        result_ready = 1'b0;
        n_entries    = 0;
        results_seen = 0;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!result_valid && issue_ready) else begin
            $display("pipeline not idle after reset, result pending or issue port busy");
            $display("Simulation failed");
            $fatal(1);
        end
        @(posedge clk);
        idx = 0;
        while (idx < n_entries) begin
            #DRIVE_DLY;
            issue_valid = 1'b1;
            issue       = test_op[idx]; // held until the pipeline takes it
            @(negedge clk);
            accepted = issue_ready;
            @(posedge clk);
            if (accepted) begin
                idx++;
            end
        end
        #DRIVE_DLY;
        issue_valid = 1'b0;
        issue       = '0;
        wait (results_seen == n_entries);
        repeat (4) @(posedge clk); // leaves room to catch a duplicate result
        $display("Simulation passed");
        $finish;
    end

    // random back-pressure and in-order result checks
    initial begin
        held        = 1'b0;
        held_result = '0;
        wait (rst_n);
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            result_ready = ($urandom % 100) < READY_PERCENT;
            @(negedge clk);
            if (held) begin
                assert (result_valid && result == held_result) else begin
                    $display("result changed or was withdrawn while waiting to be taken");
                    $display("Simulation failed");
                    $fatal(1);
                end
            end
            if (result_valid && result_ready) begin
                assert (results_seen < n_entries) else begin
                    $display("a result arrived after the last table entry was returned");
                    $display("Simulation failed");
                    $fatal(1);
                end
                assert (result.data == test_exp[results_seen]
                        && result.rd == test_op[results_seen].rd) else begin
                    $display("MISMATCH %s: expected rd %0d data %h, actual rd %0d data %h",
                             test_name[results_seen], test_op[results_seen].rd,
                             test_exp[results_seen], result.rd, result.data);
                    $display("Simulation failed");
                    $fatal(1);
                end
                results_seen++;
            end
            held        = result_valid && !result_ready;
            held_result = result;
        end
    end

    initial begin
        wait (table_ready);
        #((RESET_CYCLES + n_entries * CYCLES_PER_ENTRY) * CLK_PERIOD);
        $display("timeout, results stopped arriving after %0d of %0d entries",
                 results_seen, n_entries);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

//--- verilog.f
source/int_pipe_pkg.sv
source/reg_file.sv
source/operand_forward.sv
source/int_alu.sv
source/mem_wb_stage.sv
source/int_pipe_top.sv
testbench/tb_int_pipe.sv

//--- Bender.yml
package:
  name: int_pipe

sources:
  - source/int_pipe_pkg.sv
  - source/reg_file.sv
  - source/operand_forward.sv
  - source/int_alu.sv
  - source/mem_wb_stage.sv
  - source/int_pipe_top.sv
  - target: simulation
    files:
      - testbench/tb_int_pipe.sv
